/* all.f */
+incdir+.
dispatch_pkg.sv
rx_align.sv
frame_writer.sv
frame_ram.sv
frame_reader.sv
nts_dispatch_top.sv
tb_nts_dispatch.sv

/* Makefile */
LOG = sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the build folder and the log"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert -f all.f --top-module tb_nts_dispatch -Mdir obj_dir
	./obj_dir/Vtb_nts_dispatch > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "Something failed" $(LOG); then exit 1; fi

clean:
	rm -rf obj_dir $(LOG)

/* tb_nts_dispatch.sv */
// NTS dispatcher testbench

module tb_nts_dispatch;

  logic                clk;
  logic                areset;
  dispatch_pkg::keep_t rx_data_valid;
  dispatch_pkg::word_t rx_data;
  logic                rx_good_frame;
  logic                rx_bad_frame;
  logic                rd_start;
  logic                read_discard;
  logic                o_packet_available;
  logic [7:0]          o_dispatch_counter;
  dispatch_pkg::keep_t o_dispatch_data_valid;
  logic                o_rd_valid;
  dispatch_pkg::word_t o_rd_data;

  dispatch_pkg::word_t frame_mem [2][300];  // Payloads as sent, per slot
  dispatch_pkg::word_t exp_q [$];           // Words still due on the burst
  int                  errors;
  int                  checks;
  int                  tests_failed;

  nts_dispatch_top u_nts_dispatch_top (
    .i_clk                 (clk),
    .i_areset              (areset),
    .i_rx_data_valid       (rx_data_valid),
    .i_rx_data             (rx_data),
    .i_rx_good_frame       (rx_good_frame),
    .i_rx_bad_frame        (rx_bad_frame),
    .i_rd_start            (rd_start),
    .i_read_discard        (read_discard),
    .o_packet_available    (o_packet_available),
    .o_dispatch_counter    (o_dispatch_counter),
    .o_dispatch_data_valid (o_dispatch_data_valid),
    .o_rd_valid            (o_rd_valid),
    .o_rd_data             (o_rd_data)
  );

  initial
  begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  // --------------------
  // Reference and checks
  // --------------------
  // Valid bytes go to the top of the word, lower bytes are zero
  function automatic dispatch_pkg::word_t align_word(input dispatch_pkg::word_t data,
                                                     input dispatch_pkg::keep_t keep);
    dispatch_pkg::word_t result;
    int n_valid;
    int b;
    result  = '0;
    n_valid = 0;
    for (b = 0; b < 8; b++)
      if (keep[b])
        n_valid++;
    for (b = 0; b < n_valid; b++)
      result[(8 - n_valid + b) * 8 +: 8] = data[b * 8 +: 8];
    return result;
  endfunction

  task automatic check_value(input string name, input logic [63:0] got,
                             input logic [63:0] expected);
    checks++;
    if (got !== expected)
    begin
      $display("[FAIL] %0t %s got %h expected %h", $time, name, got, expected);
      errors++;
    end
  endtask

  // Every burst word is matched against the queue
  always @(negedge clk)
  begin
    if (!areset && o_rd_valid)
    begin
      if (exp_q.size() == 0)
      begin
        $display("Unexpected o_rd_valid at time %0t with no word left to expect", $time);
        errors++;
      end
      else
        check_value("o_rd_data", o_rd_data, exp_q.pop_front());
    end
  end

  task automatic stop_on_timeout(input string what);
    $display("Timeout at time %0t: %s", $time, what);
    $display("Something failed");
    $finish;
  endtask

  task automatic wait_available(input int limit);
    int n;
    n = 0;
    do
    begin
      @(negedge clk);
      n++;
    end while (!o_packet_available && n < limit);
    if (!o_packet_available)
      stop_on_timeout("o_packet_available never went high");
  endtask

  task automatic wait_drained(input int limit);
    int n;
    n = 0;
    while (exp_q.size() != 0 && n < limit)
    begin
      @(posedge clk);
      n++;
    end
    if (exp_q.size() != 0)
      stop_on_timeout("burst ended before all expected words arrived");
  endtask

  // --------------------
  // Stimulus
  // --------------------
  task automatic send_frame(input int slot, input int n_words,
                            input dispatch_pkg::keep_t last_keep, input logic abandon);
    int i;
    repeat (2) @(posedge clk);  // Idle gap so the start is seen
    for (i = 0; i < n_words; i++)
    begin
      @(posedge clk);
      frame_mem[slot][i] = {$urandom, $urandom};
      rx_data         <= frame_mem[slot][i];
      rx_data_valid   <= (i == n_words - 1) ? last_keep : 8'hFF;
      rx_good_frame   <= (i == n_words - 1) && !abandon;
      rx_bad_frame    <= (i == n_words - 1) && abandon;
    end
    @(posedge clk);
    rx_data       <= '0;
    rx_data_valid <= '0;
    rx_good_frame <= 1'b0;
    rx_bad_frame  <= 1'b0;
  endtask

  task automatic read_packet(input int slot, input int n_words,
                             input dispatch_pkg::keep_t last_keep);
    int exp_last;
    int i;
    exp_last = (n_words > 256) ? 255 : n_words - 1;  // Count saturates with the bank
    wait_available(100);
    check_value("o_dispatch_counter", 64'(o_dispatch_counter), 64'(exp_last));
    check_value("o_dispatch_data_valid", 64'(o_dispatch_data_valid), 64'(last_keep));
    for (i = 0; i <= exp_last; i++)
      exp_q.push_back(align_word(frame_mem[slot][i], (i == n_words - 1) ? last_keep : 8'hFF));
    @(posedge clk);
    rd_start <= 1'b1;
    @(posedge clk);
    rd_start <= 1'b0;
    wait_drained(400);
    repeat (4) @(negedge clk);  // Any extra word shows up here
  endtask

  task automatic discard_packet;
    @(posedge clk);
    read_discard <= 1'b1;
    @(posedge clk);
    read_discard <= 1'b0;
  endtask

  task automatic report_test(input int num, input string name, input int err_before);
    if (errors == err_before)
      $display("Test %0d %s: pass", num, name);
    else
    begin
      $display("Test %0d %s: fail with %0d errors", num, name, errors - err_before);
      tests_failed++;
    end
  endtask

  initial
  begin
    int seed_val;
    int err_before;
    errors        = 0;
    checks        = 0;
    tests_failed  = 0;
    seed_val      = $urandom(32'h52d855d8);
    areset        = 1'b1;
    rx_data_valid = '0;
    rx_data       = '0;
    rx_good_frame = 1'b0;
    rx_bad_frame  = 1'b0;
    rd_start      = 1'b0;
    read_discard  = 1'b0;
    repeat (5) @(posedge clk);
    areset <= 1'b0;

    err_before = errors;
    send_frame(0, 6, 8'hFF, 1'b0);
    read_packet(0, 6, 8'hFF);
    discard_packet();
    report_test(1, "full word frame", err_before);

    err_before = errors;
    send_frame(0, 5, 8'h07, 1'b0);  // 3 bytes in the last word
    read_packet(0, 5, 8'h07);
    discard_packet();
    report_test(2, "partial last word", err_before);

    err_before = errors;
    send_frame(1, 4, 8'hFF, 1'b1);
    repeat (20) @(negedge clk);
    check_value("o_packet_available", 64'(o_packet_available), 64'd0);
    send_frame(0, 7, 8'h1F, 1'b0);
    read_packet(0, 7, 8'h1F);
    discard_packet();
    report_test(3, "bad then good frame", err_before);

    err_before = errors;
    send_frame(0, 4, 8'hFF, 1'b0);
    send_frame(1, 9, 8'h3F, 1'b0);  // Lands while the first is still held
    read_packet(0, 4, 8'hFF);
    repeat (10) @(negedge clk);
    check_value("o_packet_available", 64'(o_packet_available), 64'd0);
    discard_packet();
    read_packet(1, 9, 8'h3F);
    discard_packet();
    report_test(4, "second frame waits for discard", err_before);

    err_before = errors;
    send_frame(0, 300, 8'hFF, 1'b0);
    read_packet(0, 300, 8'hFF);
    discard_packet();
    report_test(5, "oversized frame", err_before);

    $display("Tests run: 5, failed tests: %0d, checks: %0d, errors: %0d",
             tests_failed, checks, errors);
    if (errors == 0)
      $display("Everything OK");
    else
      $display("Something failed");
    $finish;
  end

endmodule

/* nts_dispatch_top.sv */
// NTS receive dispatcher

module nts_dispatch_top (
  input  logic                i_clk,
  input  logic                i_areset,
  input  dispatch_pkg::keep_t i_rx_data_valid,
  input  dispatch_pkg::word_t i_rx_data,
  input  logic                i_rx_good_frame,
  input  logic                i_rx_bad_frame,
  input  logic                i_rd_start,
  input  logic                i_read_discard,
  output logic                o_packet_available,
  output dispatch_pkg::addr_t o_dispatch_counter,
  output dispatch_pkg::keep_t o_dispatch_data_valid,
  output logic                o_rd_valid,
  output dispatch_pkg::word_t o_rd_data
);

  // Aligned receive stream
  dispatch_pkg::word_t al_word;
  dispatch_pkg::keep_t al_keep;
  logic                al_word_valid;
  logic                al_sof;
  logic                al_good;
  logic                al_bad;

  // --------------------
  // RAM ports
  // --------------------
  logic                wr_en;
  logic                wr_bank;
  dispatch_pkg::addr_t wr_addr;
  dispatch_pkg::word_t wr_data;
  logic                rd_bank;
  dispatch_pkg::addr_t rd_addr;
  dispatch_pkg::word_t ram_data;

  // Writer to reader
  logic                handoff;
  logic                handoff_bank;
  dispatch_pkg::addr_t handoff_last;
  dispatch_pkg::keep_t handoff_keep;
  logic                reader_idle;

  rx_align u_rx_align (
    .i_clk           (i_clk),
    .i_areset        (i_areset),
    .i_rx_data_valid (i_rx_data_valid),
    .i_rx_data       (i_rx_data),
    .i_rx_good_frame (i_rx_good_frame),
    .i_rx_bad_frame  (i_rx_bad_frame),
    .o_word          (al_word),
    .o_keep          (al_keep),
    .o_word_valid    (al_word_valid),
    .o_sof           (al_sof),
    .o_good          (al_good),
    .o_bad           (al_bad)
  );

  frame_writer u_frame_writer (
    .i_clk          (i_clk),
    .i_areset       (i_areset),
    .i_word         (al_word),
    .i_keep         (al_keep),
    .i_word_valid   (al_word_valid),
    .i_sof          (al_sof),
    .i_good         (al_good),
    .i_bad          (al_bad),
    .i_reader_idle  (reader_idle),
    .o_wr_en        (wr_en),
    .o_wr_bank      (wr_bank),
    .o_wr_addr      (wr_addr),
    .o_wr_data      (wr_data),
    .o_handoff      (handoff),
    .o_handoff_bank (handoff_bank),
    .o_handoff_last (handoff_last),
    .o_handoff_keep (handoff_keep)
  );

  frame_ram u_frame_ram (
    .i_clk     (i_clk),
    .i_wr_en   (wr_en),
    .i_wr_bank (wr_bank),
    .i_wr_addr (wr_addr),
    .i_wr_data (wr_data),
    .i_rd_bank (rd_bank),
    .i_rd_addr (rd_addr),
    .o_rd_data (ram_data)
  );

  frame_reader u_frame_reader (
    .i_clk                 (i_clk),
    .i_areset              (i_areset),
    .i_handoff             (handoff),
    .i_handoff_bank        (handoff_bank),
    .i_handoff_last        (handoff_last),
    .i_handoff_keep        (handoff_keep),
    .i_rd_start            (i_rd_start),
    .i_read_discard        (i_read_discard),
    .i_ram_data            (ram_data),
    .o_idle                (reader_idle),
    .o_rd_bank             (rd_bank),
    .o_rd_addr             (rd_addr),
    .o_packet_available    (o_packet_available),
    .o_dispatch_counter    (o_dispatch_counter),
    .o_dispatch_data_valid (o_dispatch_data_valid),
    .o_rd_valid            (o_rd_valid),
    .o_rd_data             (o_rd_data)
  );

endmodule

/* frame_reader.sv */
// Dispatch side frame reader

module frame_reader (
  input  logic                i_clk,
  input  logic                i_areset,
  input  logic                i_handoff,
  input  logic                i_handoff_bank,
  input  dispatch_pkg::addr_t i_handoff_last,
  input  dispatch_pkg::keep_t i_handoff_keep,
  input  logic                i_rd_start,
  input  logic                i_read_discard,
  input  dispatch_pkg::word_t i_ram_data,
  output logic                o_idle,
  output logic                o_rd_bank,
  output dispatch_pkg::addr_t o_rd_addr,
  output logic                o_packet_available,
  output dispatch_pkg::addr_t o_dispatch_counter,
  output dispatch_pkg::keep_t o_dispatch_data_valid,
  output logic                o_rd_valid,
  output dispatch_pkg::word_t o_rd_data
);

  dispatch_pkg::rd_state_e state;
  dispatch_pkg::addr_t     rd_addr;
  dispatch_pkg::addr_t     data_idx;   // Word now on the RAM output
  dispatch_pkg::addr_t     last;
  dispatch_pkg::keep_t     last_keep;
  logic                    rd_bank;

  assign data_idx = rd_addr - 1'b1;  // Address runs one ahead

  assign o_idle                = (state == dispatch_pkg::IDLE);
  assign o_packet_available    = (state == dispatch_pkg::OFFER);
  assign o_rd_bank             = rd_bank;
  assign o_rd_addr             = rd_addr;
  assign o_dispatch_counter    = last;
  assign o_dispatch_data_valid = last_keep;

  always_ff @(posedge i_clk or posedge i_areset)
  begin
    if (i_areset)
    begin
      state      <= dispatch_pkg::IDLE;
      rd_bank    <= 1'b1;  // Opposite of the writer's first bank
      rd_addr    <= '0;
      o_rd_valid <= 1'b0;
    end
    else
    begin
      o_rd_valid <= 1'b0;
      case (state)
        dispatch_pkg::IDLE:
          if (i_handoff)
          begin
            state   <= dispatch_pkg::OFFER;
            rd_bank <= i_handoff_bank;
            rd_addr <= '0;
          end
        dispatch_pkg::OFFER:
          if (i_rd_start)
            state <= dispatch_pkg::PRIME;
        dispatch_pkg::PRIME:
        begin
          rd_addr <= rd_addr + 1'b1;  // Word 0 already requested
          state   <= dispatch_pkg::STREAM;
        end
        dispatch_pkg::STREAM:
        begin
          o_rd_valid <= 1'b1;
          rd_addr    <= rd_addr + 1'b1;
          if (data_idx == last)
            state <= dispatch_pkg::DONE;
        end
        dispatch_pkg::DONE: ;  // Parked until discard
        default:
          state <= dispatch_pkg::IDLE;
      endcase

      // Free the packet from any busy state
      if (i_read_discard && (state != dispatch_pkg::IDLE))
      begin
        state      <= dispatch_pkg::IDLE;
        o_rd_valid <= 1'b0;
      end
    end
  end

  always_ff @(posedge i_clk)
  begin
    if (i_handoff && (state == dispatch_pkg::IDLE))
    begin
      last      <= i_handoff_last;
      last_keep <= i_handoff_keep;
    end
    if (state == dispatch_pkg::STREAM)
      o_rd_data <= i_ram_data;
  end

  // Valid only during the burst and its final drain cycle
  a_rd_valid_window: assert property (@(posedge i_clk) disable iff (i_areset)
    o_rd_valid |-> (state == dispatch_pkg::STREAM) ||
                   ((state == dispatch_pkg::DONE) && ($past(state) == dispatch_pkg::STREAM)));

endmodule

/* frame_ram.sv */
// Ping-pong frame memory

module frame_ram (
  input  logic                i_clk,
  input  logic                i_wr_en,
  input  logic                i_wr_bank,
  input  dispatch_pkg::addr_t i_wr_addr,
  input  dispatch_pkg::word_t i_wr_data,
  input  logic                i_rd_bank,
  input  dispatch_pkg::addr_t i_rd_addr,
  output dispatch_pkg::word_t o_rd_data
);

  localparam int DEPTH = 2 * (1 << $bits(dispatch_pkg::addr_t));  // Both banks

  dispatch_pkg::word_t mem [DEPTH];

  always_ff @(posedge i_clk)
  begin
    if (i_wr_en)
      mem[{i_wr_bank, i_wr_addr}] <= i_wr_data;
    o_rd_data <= mem[{i_rd_bank, i_rd_addr}];  // One cycle read
  end

  // Writer and reader always sit in opposite banks
  a_no_collision: assert property (@(posedge i_clk)
    !(i_wr_en && (i_wr_bank == i_rd_bank) && (i_wr_addr == i_rd_addr)));

endmodule

/* frame_writer.sv */
// Receive frame writer

module frame_writer (
  input  logic                i_clk,
  input  logic                i_areset,
  input  dispatch_pkg::word_t i_word,
  input  dispatch_pkg::keep_t i_keep,
  input  logic                i_word_valid,
  input  logic                i_sof,
  input  logic                i_good,
  input  logic                i_bad,
  input  logic                i_reader_idle,
  output logic                o_wr_en,
  output logic                o_wr_bank,
  output dispatch_pkg::addr_t o_wr_addr,
  output dispatch_pkg::word_t o_wr_data,
  output logic                o_handoff,
  output logic                o_handoff_bank,
  output dispatch_pkg::addr_t o_handoff_last,
  output dispatch_pkg::keep_t o_handoff_keep
);

  dispatch_pkg::wr_state_e state;
  dispatch_pkg::addr_t     count;      // Index of last word written
  dispatch_pkg::keep_t     last_keep;
  logic                    wr_bank;    // Bank owned by the receive side

  // --------------------
  // RAM write port
  // --------------------
  always_comb
  begin
    o_wr_en   = 1'b0;
    o_wr_addr = '0;
    case (state)
      dispatch_pkg::EMPTY:
        o_wr_en = i_sof && !i_bad;  // First word at address 0
      dispatch_pkg::HAS_DATA:
        if (i_word_valid && !i_bad && (count != '1))
        begin
          o_wr_en   = 1'b1;
          o_wr_addr = count + 1'b1;
        end
      default: ;
    endcase
  end

  assign o_wr_bank = wr_bank;
  assign o_wr_data = i_word;

  // Frame is passed over only to an idle reader
  assign o_handoff      = (state == dispatch_pkg::RECEIVED) && i_reader_idle;
  assign o_handoff_bank = wr_bank;
  assign o_handoff_last = count;
  assign o_handoff_keep = last_keep;

  always_ff @(posedge i_clk or posedge i_areset)
  begin
    if (i_areset)
    begin
      state   <= dispatch_pkg::EMPTY;
      count   <= '0;
      wr_bank <= 1'b0;
    end
    else
    begin
      case (state)
        dispatch_pkg::EMPTY:
          if (i_sof && !i_bad)
          begin
            count <= '0;
            state <= i_good ? dispatch_pkg::RECEIVED : dispatch_pkg::HAS_DATA;
          end
        dispatch_pkg::HAS_DATA:
          if (i_bad)
            state <= dispatch_pkg::EMPTY;  // Frame abandoned
          else
          begin
            if (o_wr_en)
              count <= o_wr_addr;  // Saturates at the top of the bank
            if (i_good)
              state <= dispatch_pkg::RECEIVED;
          end
        dispatch_pkg::RECEIVED:
          if (i_reader_idle)
          begin
            state   <= dispatch_pkg::EMPTY;
            wr_bank <= ~wr_bank;  // Swap ping-pong banks
          end
        default:
          state <= dispatch_pkg::EMPTY;
      endcase
    end
  end

  always_ff @(posedge i_clk)
  begin
    if (i_good && (state != dispatch_pkg::RECEIVED))
      last_keep <= i_keep;  // Mask of the final word
  end

  // Good closes the frame on its last word, so the latched mask is real
  a_good_with_word: assert property (@(posedge i_clk) disable iff (i_areset)
    i_good |-> i_word_valid);

endmodule

/* rx_align.sv */
// MAC receive alignment stage

`include "dispatch_defs.svh"

module rx_align (
  input  logic                i_clk,
  input  logic                i_areset,
  input  dispatch_pkg::keep_t i_rx_data_valid,
  input  dispatch_pkg::word_t i_rx_data,
  input  logic                i_rx_good_frame,
  input  logic                i_rx_bad_frame,
  output dispatch_pkg::word_t o_word,
  output dispatch_pkg::keep_t o_keep,
  output logic                o_word_valid,
  output logic                o_sof,
  output logic                o_good,
  output logic                o_bad
);

  dispatch_pkg::keep_t prev_keep;
  dispatch_pkg::word_t aligned;
  logic [3:0]          n_bytes;
  logic [6:0]          shift_bits;
  logic                sof_det;

  // --------------------
  // Byte order fix
  // --------------------
  // Valid bytes of a partial word move to the top, the rest become zero
  always_comb
  begin
    n_bytes    = 4'($countones(i_rx_data_valid));
    shift_bits = {4'd8 - n_bytes, 3'b000};  // Bits of padding
    aligned    = i_rx_data << shift_bits;
  end

  assign sof_det = (prev_keep == `DISP_SOF_PREV) && (i_rx_data_valid == `DISP_SOF_CUR);

  always_ff @(posedge i_clk or posedge i_areset)
  begin
    if (i_areset)
    begin
      prev_keep    <= '1;  // No false start of frame out of reset
      o_word_valid <= 1'b0;
      o_sof        <= 1'b0;
      o_good       <= 1'b0;
      o_bad        <= 1'b0;
    end
    else
    begin
      prev_keep    <= i_rx_data_valid;
      o_word_valid <= (i_rx_data_valid != '0);
      o_sof        <= sof_det;
      o_good       <= i_rx_good_frame;  // Stays with its last word
      o_bad        <= i_rx_bad_frame;
    end
  end

  always_ff @(posedge i_clk)
  begin
    o_word <= aligned;
    o_keep <= i_rx_data_valid;
  end

  // MAC masks fill from byte 0 upward
  a_keep_contiguous: assert property (@(posedge i_clk) disable iff (i_areset)
    (i_rx_data_valid != '0) |-> ((i_rx_data_valid & (i_rx_data_valid + 1'b1)) == '0));

endmodule

/* dispatch_pkg.sv */
// Dispatcher shared types

`include "dispatch_defs.svh"

package dispatch_pkg;

  typedef logic [`DISP_DATA_W-1:0] word_t;  // MAC data word
  typedef logic [`DISP_KEEP_W-1:0] keep_t;  // Byte-valid mask
  typedef logic [`DISP_ADDR_W-1:0] addr_t;  // Word index in one bank

  // Receive side, one frame in the write bank
  typedef enum logic [1:0] {
    EMPTY,
    HAS_DATA,
    RECEIVED
  } wr_state_e;

  // Dispatch side
  typedef enum logic [2:0] {
    IDLE,
    OFFER,
    PRIME,
    STREAM,
    DONE
  } rd_state_e;

endpackage

/* dispatch_defs.svh */
// Dispatcher width macros

`ifndef DISPATCH_DEFS_SVH
`define DISPATCH_DEFS_SVH

// --------------------
// Data path widths
// --------------------
`define DISP_DATA_W 64   // MAC word
`define DISP_KEEP_W 8    // One valid bit per byte
`define DISP_ADDR_W 8    // 256 words per bank

// --------------------
// Start of frame pattern
// --------------------
// Idle gap followed by the first full word
`define DISP_SOF_PREV 8'h00
`define DISP_SOF_CUR  8'hFF

`endif
